// File: bench/cpu_props.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_props (
  input logic                 clk,
  input logic                 clk_en,
  input logic                 rst_n,
  input logic                 memory_read_en,
  input logic                 memory_write_en,
  input logic [`CPU_PC_W-1:0] rom_addr,
  input logic                 dec_take,
  input logic                 exe_take,
  input logic                 irq_taken
);

  strobes_after_reset: assert property (@(posedge clk)
    !rst_n |=> !memory_read_en && !memory_write_en)
    else $error("Memory strobe high right after reset");

  no_read_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(memory_read_en && memory_write_en))
    else $error("Memory read and write strobes high together");

  // Sequential fetch when nothing steers the PC
  pc_increments: assert property (@(posedge clk) disable iff (!rst_n)
    (clk_en && !dec_take && !exe_take && !irq_taken)
      |=> rom_addr == `CPU_PC_W'($past(rom_addr) + 1))
    else $error("rom_addr did not step by one");

  pc_holds: assert property (@(posedge clk) disable iff (!rst_n)
    !clk_en |=> $stable(rom_addr))
    else $error("rom_addr moved while clk_en was low");

endmodule

bind cpu cpu_props props (
  .clk            (clk),
  .clk_en         (clk_en),
  .rst_n          (rst_n),
  .memory_read_en (memory_read_en),
  .memory_write_en(memory_write_en),
  .rom_addr       (rom_addr),
  .dec_take       (dec_redirect.take),
  .exe_take       (exe_redirect.take),
  .irq_taken      (irq_taken)
);

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();
  localparam int TIMEOUT = 4000;

  logic                       clk = 1'b0;
  logic                       clk_en = 1'b0;
  logic                       rst_n = 1'b0;
  logic [`CPU_PC_W-1:0]       rom_addr;
  logic [`CPU_OPCODE_W-1:0]   rom_data;
  logic                       memory_write_en;
  logic                       memory_read_en;
  logic [`CPU_MEM_ADDR_W-1:0] memory_addr;
  logic [`CPU_DATA_W-1:0]     memory_write_data;
  logic [`CPU_DATA_W-1:0]     memory_read_data;
  logic [`CPU_IRQ_COUNT-1:0]  interrupt_req = '0;

  logic [`CPU_OPCODE_W-1:0] rom [0:255];
  logic [`CPU_DATA_W-1:0]   mem [0:255];
  logic [11:0]              main_q[$]; // Expected stores as {addr, data}
  logic [11:0]              hdl_q[$];
  integer                   seed = 32'hc004_97ee;
  int                       asm_pc;
  int                       main_done = 0;
  int                       hdl_done = 0;
  int                       h1_main = -1; // Main stores seen when IRQ 1 first runs
  int                       errors = 0;
  int                       tests = 0;

  cpu UUT (.*);

  assign rom_data         = rom[rom_addr];
  assign memory_read_data = mem[memory_addr];

  // Data memory takes the store at the end of the enabled step
  always @(posedge clk) begin
    if (rst_n && clk_en && memory_write_en) mem[memory_addr] <= memory_write_data;
  end

  always #2 clk = ~clk;

  // **************************************************
  // Program assembly
  // **************************************************
  task automatic emit(input logic [3:0] cls, input logic [7:0] operand);
    rom[asm_pc] = {cls, operand};
    asm_pc++;
  endtask

  task automatic alu_case(input logic [3:0] a, input logic [3:0] b, input alu_op op,
                          input logic [7:0] addr, input logic [3:0] expect_val);
    emit(`CPU_OP_LDA_I, {4'h0, a});
    emit(`CPU_OP_LDB_I, {4'h0, b});
    emit(`CPU_OP_ALU, {5'h0, op});
    emit(`CPU_OP_STM, addr);
    main_q.push_back({addr, expect_val});
  endtask

  task automatic store_imm(input logic [3:0] val, input logic [7:0] addr);
    emit(`CPU_OP_LDA_I, {4'h0, val});
    emit(`CPU_OP_STM, addr);
    main_q.push_back({addr, val});
  endtask

  // Spin until the bench writes a nonzero nibble to the flag address
  task automatic poll(input logic [7:0] flag);
    int top;
    top = asm_pc;
    emit(`CPU_OP_LDM, flag);
    emit(`CPU_OP_LDB_I, 8'h00);
    emit(`CPU_OP_ALU, {5'h0, ALU_OR});
    emit(`CPU_OP_JPZ, 8'(top));
  endtask

  task automatic build_program();
    int p1;
    int p2;
    for (int i = 0; i < 256; i++) rom[i] = '0;
    rom[0] = {`CPU_OP_JP, 8'h20};
    for (int i = 0; i < `CPU_IRQ_COUNT; i++) begin
      rom[i + 1] = {`CPU_OP_JP, (i < 3) ? 8'(8'h10 + 5 * i) : 8'h1f};
    end
    for (int i = 0; i < 3; i++) begin
      asm_pc = 8'h10 + 5 * i; // Handler saves and restores A through 0xF0
      emit(`CPU_OP_STM, 8'hf0);
      emit(`CPU_OP_LDA_I, 8'(4'ha + i));
      emit(`CPU_OP_STM, 8'(8'h80 + i));
      emit(`CPU_OP_LDM, 8'hf0);
      emit(`CPU_OP_RETI, 8'h00);
    end
    rom[8'h1f] = {`CPU_OP_STM, 8'h8f}; // Trap for unused vectors
    asm_pc = 8'h20;
    alu_case(4'h9, 4'h5, ALU_ADD, 8'h00, 4'he);
    alu_case(4'h9, 4'h8, ALU_ADD, 8'h01, 4'h1); // 17 wraps, carry set
    alu_case(4'h2, 4'h3, ALU_ADC, 8'h02, 4'h6);
    alu_case(4'h3, 4'h5, ALU_SUB, 8'h03, 4'he); // Borrow set
    alu_case(4'h0, 4'h0, ALU_ADC, 8'h04, 4'h1);
    alu_case(4'hc, 4'ha, ALU_AND, 8'h05, 4'h8);
    alu_case(4'hc, 4'ha, ALU_OR, 8'h06, 4'he);
    alu_case(4'hc, 4'ha, ALU_XOR, 8'h07, 4'h6);
    emit(`CPU_OP_FLAG, 8'h00);
    alu_case(4'h7, 4'h5, ALU_ADD, 8'h08, 4'h2); // 12 in BCD is 2, carry 1
    alu_case(4'h0, 4'h0, ALU_ADC, 8'h09, 4'h1);
    alu_case(4'h4, 4'h3, ALU_ADD, 8'h0a, 4'h7);
    emit(`CPU_OP_FLAG, 8'h01);
    store_imm(4'h9, 8'h0b);
    emit(`CPU_OP_LDA_I, 8'h00);
    emit(`CPU_OP_LDM, 8'h0b);
    emit(`CPU_OP_STM, 8'h0c);
    main_q.push_back({8'h0c, 4'h9});
    store_imm(4'h5, 8'h0d);
    store_imm(4'h3, 8'h0e);
    emit(`CPU_OP_LDM, 8'h0d);
    emit(`CPU_OP_STM, 8'h0f);
    main_q.push_back({8'h0f, 4'h5});
    // **************************************************
    // Jumps, skipped stores land on 0x7D..0x7F
    // **************************************************
    p1 = asm_pc;
    emit(`CPU_OP_JP, 8'h00);
    emit(`CPU_OP_STM, 8'h7f);
    rom[p1][7:0] = 8'(asm_pc);
    alu_case(4'h1, 4'h1, ALU_SUB, 8'h10, 4'h0);
    asm_pc--;
    p1 = asm_pc;
    emit(`CPU_OP_JPZ, 8'h00);
    emit(`CPU_OP_STM, 8'h7e);
    rom[p1][7:0] = 8'(asm_pc);
    emit(`CPU_OP_STM, 8'h10);
    alu_case(4'h3, 4'h1, ALU_SUB, 8'h11, 4'h2);
    asm_pc--;
    p1 = asm_pc;
    emit(`CPU_OP_JPZ, 8'h00);
    emit(`CPU_OP_STM, 8'h11);
    p2 = asm_pc;
    emit(`CPU_OP_JP, 8'h00);
    rom[p1][7:0] = 8'(asm_pc);
    emit(`CPU_OP_STM, 8'h7d);
    rom[p2][7:0] = 8'(asm_pc);
    // **************************************************
    // Interrupt phases
    // **************************************************
    emit(`CPU_OP_FLAG, 8'h02);
    store_imm(4'h1, 8'h12);
    poll(8'he0);
    store_imm(4'h2, 8'h13);
    emit(`CPU_OP_FLAG, 8'h03);
    store_imm(4'h3, 8'h14);
    poll(8'he1);
    store_imm(4'h4, 8'h15);
    emit(`CPU_OP_FLAG, 8'h02);
    store_imm(4'h5, 8'h16);
    emit(`CPU_OP_FLAG, 8'h03);
    store_imm(4'h6, 8'h17);
    poll(8'he2);
    emit(`CPU_OP_FLAG, 8'h02);
    store_imm(4'h7, 8'h18);
    emit(`CPU_OP_JP, 8'(asm_pc));
    hdl_q = '{{8'h80, 4'ha}, {8'h81, 4'hb}, {8'h81, 4'hb}, {8'h82, 4'hc}};
  endtask

  // **************************************************
  // Stimulus and store checks
  // **************************************************
  task automatic record_store(input logic [7:0] addr, input logic [3:0] data);
    logic [11:0] exp;
    if (addr < 8'h80) begin
      assert (main_q.size() != 0) else begin
        errors++;
        $display("Unexpected main-line store of %h to address %h", data, addr);
      end
      if (main_q.size() != 0) begin
        exp = main_q.pop_front();
        assert (addr == exp[11:4]) else begin
          errors++;
          $display("** Error: memory_addr = %h, expected %h", addr, exp[11:4]);
        end
        assert (data == exp[3:0]) else begin
          errors++;
          $display("** Error: memory_write_data = %h, expected %h", data, exp[3:0]);
        end
      end
      main_done++;
    end else if (addr < 8'h90) begin
      assert (hdl_q.size() != 0 && {addr, data} == hdl_q[0]) else begin
        errors++;
        $display("** Error: handler store {memory_addr, memory_write_data} = %h, expected %h",
                 {addr, data}, (hdl_q.size() != 0) ? hdl_q[0] : 12'h0);
      end
      if (hdl_q.size() != 0) void'(hdl_q.pop_front());
      if (addr == 8'h81 && h1_main < 0) h1_main = main_done;
      hdl_done++;
    end
  endtask

  always @(negedge clk) begin
    clk_en = ($random(seed) & 3) != 0;
    if (rst_n && clk_en && memory_write_en) record_store(memory_addr, memory_write_data);
  end

  task automatic timed_out(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic wait_main(input int n, input string what);
    int cnt;
    cnt = 0;
    while (main_done < n && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (main_done < n) timed_out(what);
  endtask

  task automatic wait_handler(input int n, input string what);
    int cnt;
    cnt = 0;
    while (hdl_done < n && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (hdl_done < n) timed_out(what);
  endtask

  task automatic wait_rom(input logic [7:0] addr, input string what);
    int cnt;
    cnt = 0;
    while (rom_addr != addr && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (rom_addr != addr) timed_out(what);
  endtask

  task automatic test_done(input string name, input int start_errors);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == start_errors) ? "ok" : "FAILED");
  endtask

  initial begin
    int e;
    build_program();
    for (int i = 0; i < 256; i++) mem[i] = 4'(i) ^ 4'(i >> 4);
    mem[8'he0] = '0;
    mem[8'he1] = '0;
    mem[8'he2] = '0;
    repeat (3) @(negedge clk);
    e = errors;
    assert (rom_addr == 0 && !memory_read_en && !memory_write_en) else begin
      errors++;
      $display("** Error: rom_addr = %h, expected 00 with strobes low", rom_addr);
    end
    rst_n = 1'b1;
    test_done("reset", e);
    e = errors;
    wait_main(8, "binary ALU stores");
    test_done("binary ALU", e);
    e = errors;
    wait_main(11, "decimal ALU stores");
    test_done("decimal ALU", e);
    e = errors;
    wait_main(16, "load and store");
    test_done("load and store", e);
    e = errors;
    wait_main(18, "jump stores");
    test_done("jumps", e);
    e = errors;
    wait_main(19, "EI marker");
    interrupt_req[0] = 1'b1;
    wait_rom(8'h01, "vector 1");
    wait_handler(1, "handler 0 store");
    mem[8'he0] = 4'h1;
    wait_main(21, "DI marker");
    interrupt_req[1] = 1'b1;
    repeat (60) @(negedge clk);
    assert (hdl_done == 1) else begin
      errors++;
      $display("Interrupt 1 was served while interrupts were disabled");
    end
    mem[8'he1] = 4'h1;
    wait_handler(2, "handler 1 after EI");
    assert (h1_main >= 22) else begin
      errors++;
      $display("Interrupt 1 was served before EI executed");
    end
    wait_main(24, "second DI marker");
    interrupt_req = '0;
    repeat (8) @(negedge clk);
    interrupt_req[2:1] = 2'b11;
    mem[8'he2] = 4'h1;
    wait_handler(4, "simultaneous handlers");
    wait_main(25, "final main store");
    repeat (40) @(negedge clk);
    assert (main_q.size() == 0 && hdl_q.size() == 0) else begin
      errors++;
      $display("Expected stores never happened");
    end
    test_done("interrupts", e);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu import cpu_pkg::*; (
  input  alu_op                  op,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  logic                   carry_in,
  input  logic                   decimal_in,
  output logic [`CPU_DATA_W-1:0] result,
  output logic                   carry_out,
  output logic                   zero_out
);
  logic [`CPU_DATA_W:0] wide;

  always_comb begin
    wide      = '0;
    result    = a;
    carry_out = carry_in; // Logic operations keep the old carry
    case (op)
      ALU_ADD, ALU_ADC: begin
        wide = a + b + ((op == ALU_ADC) && carry_in);
        if (decimal_in && (wide > 'd9)) begin
          wide      = wide + 'd6; // BCD adjust, low nibble stays right after wrap
          carry_out = 1'b1;
        end else begin
          carry_out = wide[`CPU_DATA_W];
        end
        result = wide[`CPU_DATA_W-1:0];
      end
      ALU_SUB: begin
        wide      = a - b;
        result    = wide[`CPU_DATA_W-1:0];
        carry_out = wide[`CPU_DATA_W]; // Borrow
      end
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_PASS_B: result = b;
      default:    result = a;
    endcase
  end

  assign zero_out = (result == '0);

endmodule

// File: hw/cpu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       clk_en,
  input  logic                       rst_n,
  output logic [`CPU_PC_W-1:0]       rom_addr,
  input  logic [`CPU_OPCODE_W-1:0]   rom_data,
  output logic                       memory_write_en,
  output logic                       memory_read_en,
  output logic [`CPU_MEM_ADDR_W-1:0] memory_addr,
  output logic [`CPU_DATA_W-1:0]     memory_write_data,
  input  logic [`CPU_DATA_W-1:0]     memory_read_data,
  input  logic [`CPU_IRQ_COUNT-1:0]  interrupt_req
);
  fetch_slot            slot;
  decoded_instr         instr;
  redirect              dec_redirect;
  redirect              exe_redirect;
  logic                 irq_pending;
  logic [3:0]           irq_index;
  logic                 irq_taken;
  logic                 ie;
  logic [`CPU_PC_W-1:0] oldest_pc;
  logic [`CPU_PC_W-1:0] return_pc;

  fetch fetch (
    .clk         (clk),
    .clk_en      (clk_en),
    .rst_n       (rst_n),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .dec_redirect(dec_redirect),
    .exe_redirect(exe_redirect),
    .irq_pending (irq_pending),
    .irq_index   (irq_index),
    .ie          (ie),
    .oldest_pc   (oldest_pc),
    .irq_taken   (irq_taken),
    .slot        (slot),
    .return_pc   (return_pc)
  );

  decode decoder (
    .clk         (clk),
    .clk_en      (clk_en),
    .rst_n       (rst_n),
    .slot        (slot),
    .flush       (exe_redirect.take || irq_taken),
    .instr       (instr),
    .dec_redirect(dec_redirect)
  );

  execute execute (
    .clk              (clk),
    .clk_en           (clk_en),
    .rst_n            (rst_n),
    .instr            (instr),
    .irq_taken        (irq_taken),
    .return_pc        (return_pc),
    .memory_read_en   (memory_read_en),
    .memory_write_en  (memory_write_en),
    .memory_addr      (memory_addr),
    .memory_write_data(memory_write_data),
    .memory_read_data (memory_read_data),
    .exe_redirect     (exe_redirect),
    .ie               (ie),
    .oldest_pc        (oldest_pc)
  );

  interrupt_ctrl interrupts (
    .clk          (clk),
    .clk_en       (clk_en),
    .rst_n        (rst_n),
    .interrupt_req(interrupt_req),
    .irq_taken    (irq_taken),
    .irq_pending  (irq_pending),
    .irq_index    (irq_index)
  );

endmodule

// File: hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DATA_W     4
`define CPU_OPCODE_W   12
`define CPU_PC_W       8
`define CPU_MEM_ADDR_W 8
`define CPU_IRQ_COUNT  15

// Instruction class in opcode[11:8], operand in opcode[7:0]
`define CPU_OP_LDA_I 4'h0
`define CPU_OP_LDB_I 4'h1
`define CPU_OP_ALU   4'h2 // Operation select in operand[2:0]
`define CPU_OP_LDM   4'h3
`define CPU_OP_STM   4'h4
`define CPU_OP_JP    4'h5
`define CPU_OP_JPZ   4'h6
`define CPU_OP_FLAG  4'h7 // operand[1:0] selects SED, CLD, EI, DI
`define CPU_OP_RETI  4'h8

`endif

// File: hw/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_ADC    = 3'd1,
    ALU_SUB    = 3'd2,
    ALU_AND    = 3'd3,
    ALU_OR     = 3'd4,
    ALU_XOR    = 3'd5,
    ALU_PASS_B = 3'd6 // Routes immediates and memory data into A or B
  } alu_op;

  typedef struct packed {
    logic                     valid;
    logic [`CPU_PC_W-1:0]     pc;
    logic [`CPU_OPCODE_W-1:0] opcode;
  } fetch_slot;

  typedef struct packed {
    logic                 valid;
    logic [`CPU_PC_W-1:0] pc; // Still meaningful on bubbles after a jump
    logic                 dest_b;
    logic                 load_imm;
    logic                 use_alu;
    alu_op                op;
    logic                 mem_read;
    logic                 mem_write;
    logic                 jump_z;
    logic                 reti;
    logic                 set_decimal;
    logic                 clr_decimal;
    logic                 set_ie;
    logic                 clr_ie;
    logic [7:0]           operand;
  } decoded_instr;

  typedef struct packed {
    logic                 take;
    logic [`CPU_PC_W-1:0] target;
  } redirect;

endpackage

// File: hw/decode.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode import cpu_pkg::*; (
  input  logic         clk,
  input  logic         clk_en,
  input  logic         rst_n,
  input  fetch_slot    slot,
  input  logic         flush,
  output decoded_instr instr,
  output redirect      dec_redirect
);
  logic [3:0]   op_class;
  decoded_instr dec;

  assign op_class = slot.opcode[`CPU_OPCODE_W-1 -: 4];

  // **************************************************
  // Class decode
  // **************************************************
  always_comb begin
    dec         = '0;
    dec.valid   = slot.valid;
    dec.pc      = slot.pc;
    dec.operand = slot.opcode[7:0];
    dec.op      = ALU_PASS_B;
    case (op_class)
      `CPU_OP_LDA_I: dec.load_imm = 1'b1;
      `CPU_OP_LDB_I: begin
        dec.load_imm = 1'b1;
        dec.dest_b   = 1'b1;
      end
      `CPU_OP_ALU: begin
        dec.use_alu = 1'b1;
        dec.op      = alu_op'(slot.opcode[2:0]);
      end
      `CPU_OP_LDM:  dec.mem_read  = 1'b1;
      `CPU_OP_STM:  dec.mem_write = 1'b1;
      `CPU_OP_JPZ:  dec.jump_z    = 1'b1;
      `CPU_OP_FLAG: begin
        case (slot.opcode[1:0])
          2'd0:    dec.set_decimal = 1'b1;
          2'd1:    dec.clr_decimal = 1'b1;
          2'd2:    dec.set_ie      = 1'b1;
          default: dec.clr_ie      = 1'b1;
        endcase
      end
      `CPU_OP_RETI: dec.reti = 1'b1;
      default: ; // JP is finished here, unused classes run as NOP
    endcase
  end

  // JP leaves the pipe a step early and costs one bubble
  assign dec_redirect.take   = slot.valid && (op_class == `CPU_OP_JP);
  assign dec_redirect.target = slot.opcode[`CPU_PC_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr <= '0;
    end else if (clk_en) begin
      instr <= dec;
      if (flush) instr.valid <= 1'b0;
    end
  end

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       clk_en,
  input  logic                       rst_n,
  input  decoded_instr               instr,
  input  logic                       irq_taken,
  input  logic [`CPU_PC_W-1:0]       return_pc,
  output logic                       memory_read_en,
  output logic                       memory_write_en,
  output logic [`CPU_MEM_ADDR_W-1:0] memory_addr,
  output logic [`CPU_DATA_W-1:0]     memory_write_data,
  input  logic [`CPU_DATA_W-1:0]     memory_read_data,
  output redirect                    exe_redirect,
  output logic                       ie,
  output logic [`CPU_PC_W-1:0]       oldest_pc
);
  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_b;
  logic                   zero;
  logic                   carry;
  logic                   decimal;
  logic                   active;
  logic [`CPU_DATA_W-1:0] alu_b;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic                   alu_carry;
  logic                   alu_zero;
  logic                   redir_q;
  logic [`CPU_PC_W-1:0]   redir_target_q;

  // An interrupt displaces the instruction here, it reruns after RETI
  assign active = instr.valid && !irq_taken;

  assign memory_read_en    = active && instr.mem_read;
  assign memory_write_en   = active && instr.mem_write;
  assign memory_addr       = instr.operand[`CPU_MEM_ADDR_W-1:0];
  assign memory_write_data = reg_a;

  always_comb begin
    alu_b = reg_b;
    if (instr.load_imm) alu_b = instr.operand[`CPU_DATA_W-1:0];
    else if (instr.mem_read) alu_b = memory_read_data;
  end

  alu alu (
    .op        (instr.op),
    .a         (reg_a),
    .b         (alu_b),
    .carry_in  (carry),
    .decimal_in(decimal),
    .result    (alu_result),
    .carry_out (alu_carry),
    .zero_out  (alu_zero)
  );

  // **************************************************
  // Flow control
  // **************************************************
  assign exe_redirect.take   = instr.valid && ((instr.jump_z && zero) || instr.reti);
  assign exe_redirect.target = instr.reti ? return_pc : instr.operand[`CPU_PC_W-1:0];

  // The flush bubble right after a redirect holds a stale PC
  assign oldest_pc = redir_q ? redir_target_q : instr.pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_a   <= '0;
      reg_b   <= '0;
      zero    <= 1'b0;
      carry   <= 1'b0;
      decimal <= 1'b0;
      ie      <= 1'b0;
      redir_q <= 1'b0;
    end else if (clk_en) begin
      redir_q <= exe_redirect.take;
      if (active && (instr.load_imm || instr.mem_read || instr.use_alu)) begin
        if (instr.dest_b) reg_b <= alu_result;
        else reg_a <= alu_result;
      end
      if (active && instr.use_alu) begin
        zero  <= alu_zero;
        carry <= alu_carry;
      end
      if (active && instr.set_decimal) decimal <= 1'b1;
      if (active && instr.clr_decimal) decimal <= 1'b0;
      if (irq_taken) ie <= 1'b0;
      else if (active && (instr.set_ie || instr.reti)) ie <= 1'b1;
      else if (active && instr.clr_ie) ie <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en && exe_redirect.take) redir_target_q <= exe_redirect.target;
  end

endmodule

// File: hw/fetch.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     clk_en,
  input  logic                     rst_n,
  output logic [`CPU_PC_W-1:0]     rom_addr,
  input  logic [`CPU_OPCODE_W-1:0] rom_data,
  input  redirect                  dec_redirect,
  input  redirect                  exe_redirect,
  input  logic                     irq_pending,
  input  logic [3:0]               irq_index,
  input  logic                     ie,
  input  logic [`CPU_PC_W-1:0]     oldest_pc,
  output logic                     irq_taken,
  output fetch_slot                slot,
  output logic [`CPU_PC_W-1:0]     return_pc
);
  logic [`CPU_PC_W-1:0] pc;
  logic [`CPU_PC_W-1:0] next_pc;
  logic                 squash;

  assign rom_addr  = pc;
  assign irq_taken = ie && irq_pending && !exe_redirect.take && !dec_redirect.take;
  assign squash    = exe_redirect.take || dec_redirect.take || irq_taken;

  always_comb begin
    if (exe_redirect.take) next_pc = exe_redirect.target;
    else if (dec_redirect.take) next_pc = dec_redirect.target;
    else if (irq_taken) next_pc = `CPU_PC_W'(irq_index) + 1'b1; // Vector 0 is reset
    else next_pc = pc + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc   <= '0;
      slot <= '0;
    end else if (clk_en) begin
      pc          <= next_pc;
      slot.valid  <= !squash;
      slot.pc     <= squash ? next_pc : pc; // A dead slot carries the PC that follows it
      slot.opcode <= rom_data;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en && irq_taken) return_pc <= oldest_pc;
  end

endmodule

// File: hw/interrupt_ctrl.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module interrupt_ctrl (
  input  logic                      clk,
  input  logic                      clk_en,
  input  logic                      rst_n,
  input  logic [`CPU_IRQ_COUNT-1:0] interrupt_req,
  input  logic                      irq_taken,
  output logic                      irq_pending,
  output logic [3:0]                irq_index
);
  logic [`CPU_IRQ_COUNT-1:0] req_q;
  logic [`CPU_IRQ_COUNT-1:0] latched;
  logic [`CPU_IRQ_COUNT-1:0] served;

  assign served      = {{(`CPU_IRQ_COUNT-1){1'b0}}, irq_taken} << irq_index;
  assign irq_pending = |latched;

  // Lowest index wins
  always_comb begin
    irq_index = '0;
    for (int i = `CPU_IRQ_COUNT - 1; i >= 0; i--) begin
      if (latched[i]) irq_index = 4'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q   <= '0;
      latched <= '0;
    end else if (clk_en) begin
      req_q   <= interrupt_req;
      latched <= (latched & ~served) | (interrupt_req & ~req_q); // A new edge beats the clear
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f sources.f
out=$(./obj_dir/Vcpu_tb)
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

// File: sources.f
+incdir+hw
hw/cpu_pkg.sv
hw/alu.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/interrupt_ctrl.sv
hw/cpu.sv
bench/cpu_props.sv
bench/cpu_tb.sv
